// ==== sources.f ====
cache_pkg.sv
cache_way_ram.sv
cache_tag_check.sv
cache_ctrl.sv
cache_top.sv
tb_mem.sv
tb_cache.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_cache -o tb_cache

./obj_dir/tb_cache > sim.log 2>&1 || true
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
  exit 0
fi
exit 1

// ==== tb_cache.sv ====
// testbench top for the data cache, driving cpu requests and checking responses against a word model
`default_nettype none

module tb_cache;

  timeunit 1ns;
  timeprecision 1ps;

  import cache_pkg::*;

  localparam int LIMIT = 500;   // cycles per wait

  logic  i_clk;
  logic  i_rst;
  logic  i_req_valid;
  logic  i_req_write;
  addr_t i_req_addr;
  word_t i_req_wdata;
  strb_t i_req_wstrb;
  logic  i_resp_ready;
  logic  o_req_ready;
  logic  o_resp_valid;
  word_t o_resp_rdata;
  logic  o_rd_valid;
  addr_t o_rd_addr;
  logic  rd_ready;
  logic  ret_valid;
  logic  ret_last;
  word_t ret_data;
  logic  o_wr_valid;
  addr_t o_wr_addr;
  line_t o_wr_line;
  logic  wr_ready;
  int    rd_count;
  int    wr_count;

  word_t       model [addr_t];   // keyed by word address
  word_t       exp_word;
  addr_t       req_line;         // line address of the request in flight
  int          errors;
  logic [31:0] rng;
  logic        rand_ready;
  logic        stall_seen;
  word_t       stall_data;

  cache_top DUT (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_req_valid (i_req_valid), .o_req_ready (o_req_ready), .i_req_write (i_req_write),
    .i_req_addr (i_req_addr), .i_req_wdata (i_req_wdata), .i_req_wstrb (i_req_wstrb),
    .o_resp_valid (o_resp_valid), .o_resp_rdata (o_resp_rdata), .i_resp_ready (i_resp_ready),
    .o_rd_valid (o_rd_valid), .o_rd_addr (o_rd_addr), .i_rd_ready (rd_ready),
    .i_ret_valid (ret_valid), .i_ret_last (ret_last), .i_ret_data (ret_data),
    .o_wr_valid (o_wr_valid), .o_wr_addr (o_wr_addr), .o_wr_line (o_wr_line),
    .i_wr_ready (wr_ready)
  );

  tb_mem u_mem (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_rd_valid (o_rd_valid), .i_rd_addr (o_rd_addr), .o_rd_ready (rd_ready),
    .o_ret_valid (ret_valid), .o_ret_last (ret_last), .o_ret_data (ret_data),
    .i_wr_valid (o_wr_valid), .i_wr_addr (o_wr_addr), .i_wr_line (o_wr_line),
    .o_wr_ready (wr_ready), .o_rd_count (rd_count), .o_wr_count (wr_count)
  );

  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] r;
    r = x ^ (x << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic word_t ref_word(input addr_t a);
    addr_t aw;
    aw = {a[31:3], 3'b000};
    if (model.exists(aw)) begin
      return model[aw];
    end
    return {aw ^ 32'h5a5a_c3c3, ~aw};   // same pattern as the memory model
  endfunction

  function automatic word_t merge_word(input word_t old, input word_t wdata, input strb_t strb);
    word_t res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  // one request from issue to accepted response
  task automatic do_req(input logic wr, input addr_t addr, input word_t wdata,
                        input strb_t strb, output int lat, output logic mem_seen);
    int    n;
    logic  done;
    word_t val;
    lat      = 0;
    mem_seen = 1'b0;
    @(negedge i_clk);
    i_req_valid = 1'b1;
    i_req_write = wr;
    i_req_addr  = addr;
    i_req_wdata = wdata;
    i_req_wstrb = strb;
    req_line    = {addr[31:4], 4'h0};
    n = 0;
    while (!o_req_ready && n < LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_req_ready) begin
      $display("timeout: request to %h never accepted", addr);
      errors++;
      i_req_valid = 1'b0;
      return;
    end
    val = ref_word(addr);
    if (wr) begin
      val = merge_word(val, wdata, strb);
      model[{addr[31:3], 3'b000}] = val;
    end
    exp_word = val;                       // a write answers with the merged word
    @(negedge i_clk);                     // taken at the rising edge in between
    i_req_valid = 1'b0;
    while (!o_resp_valid && lat < LIMIT) begin
      mem_seen |= o_rd_valid | o_wr_valid;
      @(posedge i_clk);
      lat++;
      @(negedge i_clk);
    end
    if (!o_resp_valid) begin
      $display("timeout: no response for request to %h", addr);
      errors++;
      return;
    end
    n    = 0;
    done = 1'b0;
    while (!done && n < LIMIT) begin
      rng          = xorshift(rng);
      i_resp_ready = rand_ready ? rng[0] : 1'b1;
      @(posedge i_clk);
      done = i_resp_ready;
      n++;
      if (!done) @(negedge i_clk);
    end
    if (!done) begin
      $display("timeout: response for %h never taken", addr);
      errors++;
    end
  endtask

  // ----------------------------------------------------------
  // compare process
  // ----------------------------------------------------------
  always @(posedge i_clk) begin
    if (!i_rst) begin
      if (stall_seen) begin
        assert (o_resp_valid && !o_req_ready) else begin
          $display("response dropped or request ready during back-pressure");
          errors++;
        end
        assert (o_resp_rdata == stall_data) else begin
          $display("mismatch o_resp_rdata: expected %h, actual %h", stall_data, o_resp_rdata);
          errors++;
        end
      end
      stall_seen = o_resp_valid && !i_resp_ready;
      stall_data = o_resp_rdata;
      if (o_resp_valid && i_resp_ready) begin
        assert (o_resp_rdata == exp_word) else begin
          $display("mismatch o_resp_rdata: expected %h, actual %h", exp_word, o_resp_rdata);
          errors++;
        end
      end
      if (o_rd_valid && rd_ready) begin   // refill of the requested line
        assert (o_rd_addr == req_line) else begin
          $display("mismatch o_rd_addr: expected %h, actual %h", req_line, o_rd_addr);
          errors++;
        end
      end
      if (o_wr_valid && wr_ready) begin   // write-back holds the model's line
        assert (o_wr_addr[9:0] == req_line[9:0] && o_wr_addr[31:10] != req_line[31:10])
        else begin
          $display("write-back address %h is not another line of the set of %h",
                   o_wr_addr, req_line);
          errors++;
        end
        assert (o_wr_line == {ref_word(o_wr_addr + 32'd8), ref_word(o_wr_addr)}) else begin
          $display("mismatch o_wr_line: expected %h, actual %h",
                   {ref_word(o_wr_addr + 32'd8), ref_word(o_wr_addr)}, o_wr_line);
          errors++;
        end
      end
    end
  end

  initial begin
    int    lat;
    logic  mem_seen;
    int    cnt;
    addr_t a;
    word_t d;
    strb_t strbs [4];
    i_clk        = 1'b0;
    i_rst        = 1'b1;
    i_req_valid  = 1'b0;
    i_req_write  = 1'b0;
    i_req_addr   = '0;
    i_req_wdata  = '0;
    i_req_wstrb  = '0;
    i_resp_ready = 1'b1;
    req_line     = '0;
    errors       = 0;
    rng          = 32'd66490;
    rand_ready   = 1'b0;
    stall_seen   = 1'b0;
    stall_data   = '0;
    strbs        = '{8'h0f, 8'ha5, 8'h81, 8'hff};
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    @(negedge i_clk);
    assert (o_req_ready && !o_resp_valid && !o_rd_valid && !o_wr_valid) else begin
      $display("outputs not in their idle state after reset");
      errors++;
    end

    // first read misses, one refill
    cnt = rd_count;
    do_req(1'b0, 32'h0000_1008, '0, '0, lat, mem_seen);
    assert (rd_count - cnt == 1) else begin
      $display("mismatch rd_count: expected %h, actual %h", 1, rd_count - cnt);
      errors++;
    end

    // same line hits in two cycles
    do_req(1'b0, 32'h0000_1000, '0, '0, lat, mem_seen);
    assert (lat == 2 && !mem_seen) else begin
      $display("hit took %0d cycles or went to memory", lat);
      errors++;
    end

    // strobed writes to both words
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      d   = {rng, ~rng};
      a   = (i % 2 == 1) ? 32'h0000_1008 : 32'h0000_1000;
      do_req(1'b1, a, d, strbs[i/2], lat, mem_seen);
      do_req(1'b0, a, '0, '0, lat, mem_seen);
    end

    // five tags in one set
    cnt = wr_count;
    for (int t = 1; t <= 5; t++) begin
      rng = xorshift(rng);
      do_req(1'b1, {22'(t), 6'd5, 4'd0}, {rng, rng}, 8'hff, lat, mem_seen);
    end
    for (int t = 1; t <= 5; t++) begin
      do_req(1'b0, {22'(t), 6'd5, 4'd0}, '0, '0, lat, mem_seen);
    end
    assert (wr_count > cnt) else begin
      $display("no write-back seen after evictions");
      errors++;
    end

    // random mix with back-pressure
    rand_ready = 1'b1;
    for (int i = 0; i < 300; i++) begin
      rng = xorshift(rng);
      a   = {19'd0, rng[2:0], 5'd0, rng[3], rng[4], 3'd0};
      d   = {rng, xorshift(rng)};
      do_req(rng[5], a, d, rng[15:8], lat, mem_seen);
    end
    rand_ready = 1'b0;

    repeat (4) @(negedge i_clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_mem.sv ====
// backing memory model for the cache testbench, serving line refills and write-backs with random stalls
`default_nettype none

module tb_mem (
  input  wire               i_clk,
  input  wire               i_rst,
  input  wire               i_rd_valid,
  input  cache_pkg::addr_t  i_rd_addr,
  output logic              o_rd_ready,
  output logic              o_ret_valid,
  output logic              o_ret_last,
  output cache_pkg::word_t  o_ret_data,
  input  wire               i_wr_valid,
  input  cache_pkg::addr_t  i_wr_addr,
  input  cache_pkg::line_t  i_wr_line,
  output logic              o_wr_ready,
  output int                o_rd_count,
  output int                o_wr_count
);

  timeunit 1ns;
  timeprecision 1ps;

  import cache_pkg::*;

  line_t       store [logic [27:0]];   // keyed by line address
  line_t       ret_line;
  int          rd_count = 0;
  int          wr_count = 0;
  int          sent;
  int          beat;
  logic [31:0] rng;

  assign o_rd_count = rd_count;
  assign o_wr_count = wr_count;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] r;
    r = x ^ (x << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  // initial contents, a fixed function of the word address
  function automatic word_t init_word(input addr_t a);
    addr_t aw;
    aw = {a[31:3], 3'b000};
    return {aw ^ 32'h5a5a_c3c3, ~aw};
  endfunction

  function automatic line_t read_line(input addr_t a);
    addr_t la;
    la = {a[31:4], 4'h0};
    if (store.exists(la[31:4])) begin
      return store[la[31:4]];
    end
    return {init_word(la + 32'd8), init_word(la)};
  endfunction

  // ----------------------------------------------------------
  // handshakes, sampled on the rising edge
  // ----------------------------------------------------------
  always @(posedge i_clk) begin
    if (!i_rst) begin
      if (i_rd_valid && o_rd_ready) begin
        ret_line <= read_line(i_rd_addr);
        rd_count <= rd_count + 1;
      end
      if (i_wr_valid && o_wr_ready) begin
        store[i_wr_addr[31:4]] = i_wr_line;
        wr_count <= wr_count + 1;
      end
    end
  end

  // outputs change on the falling edge only
  initial begin
    o_rd_ready  = 1'b0;
    o_wr_ready  = 1'b0;
    o_ret_valid = 1'b0;
    o_ret_last  = 1'b0;
    o_ret_data  = '0;
    sent        = 0;
    beat        = 0;
    rng         = 32'd66490;
    forever begin
      @(negedge i_clk);
      rng         = xorshift(rng);
      o_ret_valid = 1'b0;
      o_ret_last  = 1'b0;
      if (sent != rd_count && rng[1:0] != 2'b00) begin   // gap one time in four
        o_ret_valid = 1'b1;
        o_ret_data  = ret_line[beat*DATA_W +: DATA_W];
        o_ret_last  = (beat == BEATS_PER_LINE - 1);
        if (beat == BEATS_PER_LINE - 1) begin
          beat = 0;
          sent++;
        end else begin
          beat++;
        end
      end
      o_rd_ready = (sent == rd_count) && (rng[3:2] != 2'b00);
      o_wr_ready = (rng[5:4] != 2'b00);
    end
  end

endmodule

`default_nettype wire

// ==== cache_top.sv ====
// top level of the write-back data cache, joining controller, tag check and way rams
`default_nettype none

module cache_top (
  input  logic             i_clk,
  input  logic             i_rst,
  // cpu request
  input  logic             i_req_valid,
  output logic             o_req_ready,
  input  logic             i_req_write,
  input  cache_pkg::addr_t i_req_addr,
  input  cache_pkg::word_t i_req_wdata,
  input  cache_pkg::strb_t i_req_wstrb,
  // cpu response
  output logic             o_resp_valid,
  output cache_pkg::word_t o_resp_rdata,
  input  logic             i_resp_ready,
  // memory read request and refill return
  output logic             o_rd_valid,
  output cache_pkg::addr_t o_rd_addr,
  input  logic             i_rd_ready,
  input  logic             i_ret_valid,
  input  logic             i_ret_last,
  input  cache_pkg::word_t i_ret_data,
  // memory write-back
  output logic             o_wr_valid,
  output cache_pkg::addr_t o_wr_addr,
  output cache_pkg::line_t o_wr_line,
  input  logic             i_wr_ready
);

  import cache_pkg::*;

  way_vec_t ram_en;
  way_vec_t data_we;
  way_vec_t tag_we;
  index_t   ram_index;
  line_t    line_wdata;
  tag_t     tag_wdata;
  line_t    way_lines [NUM_WAYS];
  tag_t     way_tags  [NUM_WAYS];

  tag_t     req_tag;
  logic     hit;
  way_vec_t hit_way;
  way_vec_t victim_way;
  logic     victim_dirty;
  tag_t     victim_tag;
  logic     fill;
  way_vec_t fill_way;
  logic     set_dirty;

  cache_ctrl u_ctrl (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_req_valid    (i_req_valid),
    .o_req_ready    (o_req_ready),
    .i_req_write    (i_req_write),
    .i_req_addr     (i_req_addr),
    .i_req_wdata    (i_req_wdata),
    .i_req_wstrb    (i_req_wstrb),
    .o_resp_valid   (o_resp_valid),
    .o_resp_rdata   (o_resp_rdata),
    .i_resp_ready   (i_resp_ready),
    .o_rd_valid     (o_rd_valid),
    .o_rd_addr      (o_rd_addr),
    .i_rd_ready     (i_rd_ready),
    .i_ret_valid    (i_ret_valid),
    .i_ret_last     (i_ret_last),
    .i_ret_data     (i_ret_data),
    .o_wr_valid     (o_wr_valid),
    .o_wr_addr      (o_wr_addr),
    .o_wr_line      (o_wr_line),
    .i_wr_ready     (i_wr_ready),
    .o_ram_en       (ram_en),
    .o_data_we      (data_we),
    .o_tag_we       (tag_we),
    .o_ram_index    (ram_index),
    .o_line_wdata   (line_wdata),
    .o_tag_wdata    (tag_wdata),
    .i_way_lines    (way_lines),
    .o_req_tag      (req_tag),
    .i_hit          (hit),
    .i_hit_way      (hit_way),
    .i_victim_way   (victim_way),
    .i_victim_dirty (victim_dirty),
    .i_victim_tag   (victim_tag),
    .o_fill         (fill),
    .o_fill_way     (fill_way),
    .o_set_dirty    (set_dirty)
  );

  // dirty on a write hit goes to the way that just hit
  cache_tag_check u_tag_check (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_index        (ram_index),
    .i_req_tag      (req_tag),
    .i_way_tags     (way_tags),
    .i_fill         (fill),
    .i_fill_way     (fill_way),
    .i_set_dirty    (set_dirty),
    .i_hit_way      (hit_way),
    .o_hit          (hit),
    .o_hit_way      (hit_way),
    .o_victim_way   (victim_way),
    .o_victim_dirty (victim_dirty),
    .o_victim_tag   (victim_tag)
  );

  // ----------------------------------------------------------
  // one data ram and one tag ram per way
  // ----------------------------------------------------------
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    cache_way_ram #(
      .entry_t (line_t)
    ) u_data_ram (
      .i_clk   (i_clk),
      .i_en    (ram_en[w]),
      .i_we    (data_we[w]),
      .i_index (ram_index),
      .i_wdata (line_wdata),
      .o_rdata (way_lines[w])
    );

    cache_way_ram #(
      .entry_t (tag_t)
    ) u_tag_ram (
      .i_clk   (i_clk),
      .i_en    (ram_en[w]),
      .i_we    (tag_we[w]),
      .i_index (ram_index),
      .i_wdata (tag_wdata),
      .o_rdata (way_tags[w])
    );
  end

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
// request FSM of the data cache, sequencing lookup, write-back, refill and the cpu response
`default_nettype none

module cache_ctrl (
  input  logic                i_clk,
  input  logic                i_rst,
  // cpu request
  input  logic                i_req_valid,
  output logic                o_req_ready,
  input  logic                i_req_write,
  input  cache_pkg::addr_t    i_req_addr,
  input  cache_pkg::word_t    i_req_wdata,
  input  cache_pkg::strb_t    i_req_wstrb,
  // cpu response
  output logic                o_resp_valid,
  output cache_pkg::word_t    o_resp_rdata,
  input  logic                i_resp_ready,
  // memory read request and refill return
  output logic                o_rd_valid,
  output cache_pkg::addr_t    o_rd_addr,
  input  logic                i_rd_ready,
  input  logic                i_ret_valid,
  input  logic                i_ret_last,
  input  cache_pkg::word_t    i_ret_data,
  // memory write-back
  output logic                o_wr_valid,
  output cache_pkg::addr_t    o_wr_addr,
  output cache_pkg::line_t    o_wr_line,
  input  logic                i_wr_ready,
  // way rams
  output cache_pkg::way_vec_t o_ram_en,
  output cache_pkg::way_vec_t o_data_we,
  output cache_pkg::way_vec_t o_tag_we,
  output cache_pkg::index_t   o_ram_index,
  output cache_pkg::line_t    o_line_wdata,
  output cache_pkg::tag_t     o_tag_wdata,
  input  cache_pkg::line_t    i_way_lines [cache_pkg::NUM_WAYS],
  // tag check
  output cache_pkg::tag_t     o_req_tag,
  input  logic                i_hit,
  input  cache_pkg::way_vec_t i_hit_way,
  input  cache_pkg::way_vec_t i_victim_way,
  input  logic                i_victim_dirty,
  input  cache_pkg::tag_t     i_victim_tag,
  output logic                o_fill,
  output cache_pkg::way_vec_t o_fill_way,
  output logic                o_set_dirty
);

  import cache_pkg::*;

  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    LOOKUP     = 3'd1,
    WRITEBACK  = 3'd2,
    REFILL_REQ = 3'd3,
    REFILL     = 3'd4,
    FILL       = 3'd5,
    RESPOND    = 3'd6
  } state_e;

  state_e                            state_q;
  logic                              lookup_rd_q;  // rams hold the set
  logic [$clog2(BEATS_PER_LINE)-1:0] beat_q;

  // request buffer
  logic     req_write_q;
  addr_t    req_addr_q;
  word_t    req_wdata_q;
  strb_t    req_wstrb_q;

  way_vec_t victim_q;
  tag_t     wb_tag_q;
  line_t    line_q;      // victim line, then refill line
  word_t    resp_q;

  index_t   req_index;
  logic     req_hi;      // upper word of the line
  logic     accept;
  logic     compare;
  line_t    hit_line;
  line_t    victim_line;
  line_t    hit_new;
  line_t    fill_line;

  // strobed bytes take the write data, the rest keep the line
  function automatic line_t merge_line(line_t line, logic hi,
                                       word_t wdata, strb_t wstrb);
    line_t res;
    res = line;
    for (int b = 0; b < STRB_W; b++) begin
      if (wstrb[b]) begin
        res[(int'(hi) * STRB_W + b) * 8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic word_t line_word(line_t line, logic hi);
    return line[int'(hi) * DATA_W +: DATA_W];
  endfunction

  assign req_index = req_addr_q[OFFSET_W +: INDEX_W];
  assign req_hi    = req_addr_q[OFFSET_W-1];
  assign o_req_tag = req_addr_q[ADDR_W-1 -: TAG_W];
  assign accept    = i_req_valid && o_req_ready;
  assign compare   = (state_q == LOOKUP) && lookup_rd_q;

  // ----------------------------------------------------------
  // way select and merge
  // ----------------------------------------------------------
  always_comb begin
    hit_line    = '0;
    victim_line = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (i_hit_way[w]) begin
        hit_line |= i_way_lines[w];
      end
      if (i_victim_way[w]) begin
        victim_line |= i_way_lines[w];
      end
    end
  end

  assign hit_new   = req_write_q ? merge_line(hit_line, req_hi, req_wdata_q, req_wstrb_q)
                                 : hit_line;
  assign fill_line = req_write_q ? merge_line(line_q, req_hi, req_wdata_q, req_wstrb_q)
                                 : line_q;

  // ram and tag check controls
  always_comb begin
    o_ram_en     = '0;
    o_data_we    = '0;
    o_tag_we     = '0;
    o_line_wdata = hit_new;
    o_fill       = 1'b0;
    o_set_dirty  = 1'b0;
    case (state_q)
      LOOKUP: begin
        if (!lookup_rd_q) begin
          o_ram_en = '1;                  // read every way of the set
        end else if (i_hit && req_write_q) begin
          o_ram_en    = i_hit_way;
          o_data_we   = i_hit_way;
          o_set_dirty = 1'b1;
        end
      end
      FILL: begin
        o_ram_en     = victim_q;
        o_data_we    = victim_q;
        o_tag_we     = victim_q;
        o_line_wdata = fill_line;
        o_fill       = 1'b1;
        o_set_dirty  = req_write_q;
      end
      default: ;
    endcase
  end

  assign o_ram_index  = req_index;
  assign o_tag_wdata  = o_req_tag;
  assign o_fill_way   = victim_q;

  assign o_req_ready  = (state_q == IDLE);
  assign o_resp_valid = (state_q == RESPOND);
  assign o_resp_rdata = resp_q;
  assign o_wr_valid   = (state_q == WRITEBACK);
  assign o_wr_addr    = {wb_tag_q, req_index, {OFFSET_W{1'b0}}};
  assign o_wr_line    = line_q;
  assign o_rd_valid   = (state_q == REFILL_REQ);
  assign o_rd_addr    = {o_req_tag, req_index, {OFFSET_W{1'b0}}};

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q     <= IDLE;
      lookup_rd_q <= 1'b0;
      beat_q      <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          lookup_rd_q <= !lookup_rd_q;    // read cycle, then compare cycle
          if (lookup_rd_q) begin
            if (i_hit) begin
              state_q <= RESPOND;
            end else if (i_victim_dirty) begin
              state_q <= WRITEBACK;
            end else begin
              state_q <= REFILL_REQ;
            end
          end
        end
        WRITEBACK: begin
          if (i_wr_ready) begin
            state_q <= REFILL_REQ;
          end
        end
        REFILL_REQ: begin
          if (i_rd_ready) begin
            state_q <= REFILL;
            beat_q  <= '0;
          end
        end
        REFILL: begin
          if (i_ret_valid) begin
            beat_q <= beat_q + 1'b1;
            if (i_ret_last) begin
              state_q <= FILL;
            end
          end
        end
        FILL:    state_q <= RESPOND;
        RESPOND: begin
          if (i_resp_ready) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // request buffer, victim capture and refill line
  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_write_q <= i_req_write;
      req_addr_q  <= i_req_addr;
      req_wdata_q <= i_req_wdata;
      req_wstrb_q <= i_req_wstrb;
    end
    if (compare) begin
      resp_q   <= line_word(hit_new, req_hi);   // read word or merged word
      victim_q <= i_victim_way;
      wb_tag_q <= i_victim_tag;
      line_q   <= victim_line;
    end
    if ((state_q == REFILL) && i_ret_valid) begin
      line_q[int'(beat_q) * DATA_W +: DATA_W] <= i_ret_data;   // beat 0 is the low word
    end
    if (state_q == FILL) begin
      resp_q <= line_word(fill_line, req_hi);
    end
  end

endmodule

`default_nettype wire

// ==== cache_tag_check.sv ====
// valid and dirty state per way, hit detection and victim choice for the set under lookup
`default_nettype none

module cache_tag_check (
  input  logic                i_clk,
  input  logic                i_rst,
  input  cache_pkg::index_t   i_index,
  input  cache_pkg::tag_t     i_req_tag,
  input  cache_pkg::tag_t     i_way_tags [cache_pkg::NUM_WAYS],
  input  logic                i_fill,
  input  cache_pkg::way_vec_t i_fill_way,
  input  logic                i_set_dirty,
  input  cache_pkg::way_vec_t i_hit_way,
  output logic                o_hit,
  output cache_pkg::way_vec_t o_hit_way,
  output cache_pkg::way_vec_t o_victim_way,
  output logic                o_victim_dirty,
  output cache_pkg::tag_t     o_victim_tag
);

  import cache_pkg::*;

  way_vec_t   valid_q [NUM_SETS];
  way_vec_t   dirty_q [NUM_SETS];
  logic [1:0] lfsr_q;             // never zero, cycles 3, 1, 2

  way_vec_t   set_valid;
  way_vec_t   set_dirty;
  logic [1:0] victim_idx;
  logic       found_free;

  assign set_valid = valid_q[i_index];
  assign set_dirty = dirty_q[i_index];

  // ----------------------------------------------------------
  // tag compare
  // ----------------------------------------------------------
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      o_hit_way[w] = set_valid[w] && (i_way_tags[w] == i_req_tag);
    end
  end

  assign o_hit = |o_hit_way;

  // lowest invalid way wins, otherwise the lfsr picks
  always_comb begin
    victim_idx = lfsr_q;
    found_free = 1'b0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!set_valid[w] && !found_free) begin
        victim_idx = w[1:0];
        found_free = 1'b1;
      end
    end
  end

  assign o_victim_way   = way_vec_t'(1'b1) << victim_idx;
  assign o_victim_dirty = set_valid[victim_idx] && set_dirty[victim_idx];
  assign o_victim_tag   = i_way_tags[victim_idx];

  // ----------------------------------------------------------
  // state bits and lfsr
  // ----------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
      lfsr_q <= 2'b11;
    end else if (i_fill) begin
      valid_q[i_index] <= set_valid | i_fill_way;
      // a write miss leaves the new line dirty, a read miss clean
      dirty_q[i_index] <= i_set_dirty ? (set_dirty | i_fill_way)
                                      : (set_dirty & ~i_fill_way);
      lfsr_q           <= {lfsr_q[0] ^ lfsr_q[1], lfsr_q[1]};
    end else if (i_set_dirty) begin
      dirty_q[i_index] <= set_dirty | i_hit_way;   // write hit
    end
  end

endmodule

`default_nettype wire

// ==== cache_way_ram.sv ====
// behavioral single-port ram with one entry per set, instantiated per way for lines and for tags
`default_nettype none

module cache_way_ram #(
  parameter type entry_t = logic
) (
  input  logic              i_clk,
  input  logic              i_en,
  input  logic              i_we,
  input  cache_pkg::index_t i_index,
  input  entry_t            i_wdata,
  output entry_t            o_rdata
);

  import cache_pkg::*;

  entry_t mem [NUM_SETS];

  // registered read, one cycle latency
  // a write returns the entry it replaces
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_rdata <= mem[i_index];
      if (i_we) begin
        mem[i_index] <= i_wdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
// geometry, address fields and shared types of the data cache, imported by every cache module
`default_nettype none

package cache_pkg;

  // ----------------------------------------------------------
  // geometry
  // ----------------------------------------------------------
  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 64;               // cpu word and memory beat
  localparam int STRB_W         = DATA_W / 8;       // one bit per byte
  localparam int LINE_BYTES     = 16;
  localparam int LINE_W         = LINE_BYTES * 8;
  localparam int NUM_WAYS       = 4;
  localparam int NUM_SETS       = 64;               // 4 KiB / 16 B / 4 ways
  localparam int BEATS_PER_LINE = LINE_W / DATA_W;

  // address split: tag [31:10], index [9:4], offset [3:0]
  localparam int OFFSET_W = $clog2(LINE_BYTES);
  localparam int INDEX_W  = $clog2(NUM_SETS);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // ----------------------------------------------------------
  // types
  // ----------------------------------------------------------
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   word_t;
  typedef logic [STRB_W-1:0]   strb_t;
  typedef logic [LINE_W-1:0]   line_t;      // low word at offset 0
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [NUM_WAYS-1:0] way_vec_t;   // one-hot way select

endpackage

`default_nettype wire
